/* hw/demodPkg.sv */
/* Shared constants and types for the multi-h glue logic.
   Host addresses are 16-bit word aligned, so bit 0 never reaches the bus.
   All widths are fixed by the DAC parts and the trellis output format. */

package demodPkg;

  //**********************************************************
  // Version and reset
  //**********************************************************
  localparam logic [15:0] VerNumber = 16'h0079;
  localparam int ResetStretch = 6;                   // Cycles held after trigger
  localparam int ResetCntWidth = $clog2(ResetStretch + 1);

  //**********************************************************
  // Widths
  //**********************************************************
  localparam int DacWidth = 14;
  localparam int TrellisWidth = 18;
  localparam int HostDataWidth = 16;
  localparam int HostAddrWidth = 11;                 // Address bits 11 down to 1

  //**********************************************************
  // Host address map
  //**********************************************************
  // Misc space is the top nibble, the rest reads 0
  localparam logic [3:0] MiscSpace = 4'hF;
  localparam logic [11:0] MiscResetAddr = 12'hF00;   // Write starts soft reset
  localparam logic [11:0] MiscVersionAddr = 12'hF04; // Version in upper half

  //**********************************************************
  // Enums
  //**********************************************************
  typedef enum logic [3:0] {
    ModeLegacy = 4'd0,
    ModeMultih = 4'd5,
    ModeAuqpsk = 4'd7
  } demodMode_t;

  typedef enum logic [3:0] {
    DacDirect       = 4'd0,
    DacTrellisI     = 4'd4,
    DacTrellisQ     = 4'd5,
    DacTrellisPhErr = 4'd6,
    DacTrellisIndex = 4'd7
  } dacSel_t;

  //**********************************************************
  // Structs
  //**********************************************************
  // Synchronous host request, live whenever cs is high
  typedef struct packed {
    logic                     cs;
    logic                     wr;
    logic                     rd;
    logic [HostAddrWidth-1:0] addr;   // Word address, byte bit dropped
    logic [HostDataWidth-1:0] wrData;
  } hostReq_t;

  typedef struct packed {
    logic [HostDataWidth-1:0] rdData;
    logic                     rdValid;  // One cycle after the read
  } hostRsp_t;

  typedef struct packed {
    logic [TrellisWidth-1:0] data;
    logic                    sync;      // Sample valid for the DAC
  } trellisChan_t;

  // Bit decoder input stream
  typedef struct packed {
    logic i;
    logic q;
    logic symEn;
    logic sym2xEn;
  } decIn_t;

endpackage

/* hw/resetGen.sv */
/* Core reset generator. The soft request must be a pulse on ck933.
   Once the trigger is gone the core reset is held ResetStretch more cycles. */

`timescale 1ns/100ps

module resetGen (
  input  logic ck933,
  input  logic rs,
  input  logic softReset_i,
  output logic coreReset_o
);

  import demodPkg::*;

  logic                     softSync;   // Registered soft request
  logic [ResetCntWidth-1:0] stretchCnt;

  // Output register supplies the last stretch cycle, hence the load of one less
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      softSync    <= 1'b0;
      stretchCnt  <= ResetCntWidth'(ResetStretch - 1);
      coreReset_o <= 1'b1;
    end else begin
      softSync <= softReset_i;
      if (softSync) begin
        stretchCnt  <= ResetCntWidth'(ResetStretch - 1);
        coreReset_o <= 1'b1;
      end else if (stretchCnt != '0) begin
        stretchCnt  <= stretchCnt - 1'b1;
        coreReset_o <= 1'b1;
      end else begin
        coreReset_o <= 1'b0;                // Stretch done
      end
    end
  end

  // Downstream logic relies on a minimum reset length
  aMinResetLen : assert property (
    @(posedge ck933) $rose(coreReset_o) |-> coreReset_o [*ResetStretch]
  ) else $error("coreReset_o shorter than %0d cycles", ResetStretch);

endmodule

/* hw/hostRegs.sv */
/* Host register space. Only the misc space is decoded here.
   Reads return one cycle later; writes take effect at the next edge.
   No wait states, so the host must not expect back-pressure. */

`timescale 1ns/100ps

module hostRegs (
  input  logic               ck933,
  input  logic               rs,
  input  demodPkg::hostReq_t hostReq_i,
  output demodPkg::hostRsp_t hostRsp_o,
  output logic               softReset_o
);

  import demodPkg::*;

  logic [HostAddrWidth:0]     fullAddr;   // Byte address, bit 0 always zero
  logic                       miscSel;
  logic [2*HostDataWidth-1:0] miscWord;
  logic [HostDataWidth-1:0]   rdMux;
  logic [HostDataWidth-1:0]   rdData;
  logic                       rdValid;

  //**********************************************************
  // Address decode and read mux
  //**********************************************************
  always_comb begin
    fullAddr = {hostReq_i.addr, 1'b0};
    miscSel  = hostReq_i.cs && (fullAddr[11:8] == MiscSpace);
    miscWord = '0;
    if (miscSel && ({fullAddr[11:2], 2'b00} == MiscVersionAddr)) begin
      miscWord = {VerNumber, {HostDataWidth{1'b0}}};
    end
    // Upper half on odd word address
    if (fullAddr[1]) begin
      rdMux = miscWord[2*HostDataWidth-1:HostDataWidth];
    end else begin
      rdMux = miscWord[HostDataWidth-1:0];
    end
  end

  //**********************************************************
  // Registered response and soft reset
  //**********************************************************
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      rdValid     <= 1'b0;
      softReset_o <= 1'b0;
    end else begin
      rdValid     <= hostReq_i.cs && hostReq_i.rd;
      softReset_o <= miscSel && hostReq_i.wr && (fullAddr == MiscResetAddr);
    end
  end

  always_ff @(posedge ck933) begin
    rdData <= rdMux;
  end

  assign hostRsp_o.rdData  = rdData;
  assign hostRsp_o.rdValid = rdValid;

  // A response never appears without a request the cycle before
  aRdValidPulse : assert property (
    @(posedge ck933) disable iff (rs)
    rdValid |-> $past(hostReq_i.cs && hostReq_i.rd)
  ) else $error("rdValid without a read request");

endmodule

/* hw/inputReclock.sv */
/* Input register stage for all data from outside the chip.
   Adds one cycle of latency to every path; selects and mode are not
   reclocked here and must be quasi-static. */

`timescale 1ns/100ps

module inputReclock (
  input  logic                                    ck933,
  input  logic                                    rs,
  input  logic [2:0][demodPkg::DacWidth-1:0]      dacData_i,
  input  demodPkg::trellisChan_t [2:0]            trellisChan_i,
  input  demodPkg::decIn_t                        trellisDec_i,
  input  demodPkg::decIn_t                        legacyDec_i,
  output logic [2:0][demodPkg::DacWidth-1:0]      dacData_o,
  output demodPkg::trellisChan_t [2:0]            trellisChan_o,
  output demodPkg::decIn_t                        trellisDec_o,
  output demodPkg::decIn_t                        legacyDec_o
);

  import demodPkg::*;

  //**********************************************************
  // Reclock registers
  //**********************************************************
  // Enables and syncs must come out of reset low
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      dacData_o     <= '0;
      trellisChan_o <= '0;
      trellisDec_o  <= '0;
      legacyDec_o   <= '0;
    end else begin
      dacData_o     <= dacData_i;       // Direct DAC words
      trellisChan_o <= trellisChan_i;   // Trellis DAC channels with sync
      trellisDec_o  <= trellisDec_i;
      legacyDec_o   <= legacyDec_i;
    end
  end

endmodule

/* hw/dacChannel.sv */
/* One DAC channel. The trellis source is used only in multi-h mode.
   The output register holds while sync is low; data leaves as offset binary.
   Two cycles from data or select at this block to dacOut_o. */

`timescale 1ns/100ps

module dacChannel (
  input  logic                          ck933,
  input  logic                          coreReset_i,
  input  demodPkg::dacSel_t             dacSel_i,
  input  demodPkg::demodMode_t          demodMode_i,
  input  logic [demodPkg::DacWidth-1:0] direct_i,
  input  demodPkg::trellisChan_t        trellis_i,
  output logic [demodPkg::DacWidth-1:0] dacOut_o
);

  import demodPkg::*;

  logic                trellisSel;
  logic [DacWidth-1:0] nextData;
  logic                nextSync;
  logic [DacWidth-1:0] selData;    // Select stage
  logic                selSync;

  //**********************************************************
  // Source select
  //**********************************************************
  always_comb begin
    trellisSel = (dacSel_i inside {DacTrellisI, DacTrellisQ, DacTrellisPhErr,
                                   DacTrellisIndex})
                 && (demodMode_i == ModeMultih);
    if (trellisSel) begin
      nextData = trellis_i.data[TrellisWidth-1 -: DacWidth];  // Top bits only
      nextSync = trellis_i.sync;
    end else begin
      nextData = direct_i;
      nextSync = 1'b1;              // Direct data every cycle
    end
  end

  always_ff @(posedge ck933) begin
    selData <= nextData;
  end

  //**********************************************************
  // Output register
  //**********************************************************
  always_ff @(posedge ck933 or posedge coreReset_i) begin
    if (coreReset_i) begin
      selSync  <= 1'b0;
      dacOut_o <= {1'b1, {(DacWidth-1){1'b0}}};  // Offset binary zero
    end else begin
      selSync <= nextSync;
      if (selSync) begin
        // Flip sign bit, two's complement to offset binary
        dacOut_o <= {~selData[DacWidth-1], selData[DacWidth-2:0]};
      end
    end
  end

  // DAC sees a held sample between syncs
  aHoldOnSync : assert property (
    @(posedge ck933) disable iff (coreReset_i)
    !selSync |=> $stable(dacOut_o)
  ) else $error("dacOut_o changed without sync");

endmodule

/* hw/decoderSourceSelect.sv */
/* Bit decoder feed. Multi-h mode takes the trellis decisions, every other
   mode the legacy stream, which gets one extra register to line up with
   the legacy demodulator timing. */

`timescale 1ns/100ps

module decoderSourceSelect (
  input  logic                 ck933,
  input  logic                 coreReset_i,
  input  demodPkg::demodMode_t demodMode_i,
  input  demodPkg::decIn_t     trellisDec_i,
  input  demodPkg::decIn_t     legacyDec_i,
  output demodPkg::decIn_t     decOut_o
);

  import demodPkg::*;

  decIn_t legacyDly;
  logic   trellisEn;

  assign trellisEn = (demodMode_i == ModeMultih);

  //**********************************************************
  // Legacy delay and mode mux
  //**********************************************************
  always_ff @(posedge ck933 or posedge coreReset_i) begin
    if (coreReset_i) begin
      legacyDly <= '0;
      decOut_o  <= '0;              // Enables low in reset
    end else begin
      legacyDly <= legacyDec_i;
      if (trellisEn) begin
        decOut_o <= trellisDec_i;
      end else begin
        decOut_o <= legacyDly;      // Legacy and AU-QPSK
      end
    end
  end

endmodule

/* hw/multihTop.sv */
/* Glue around the multi-h trellis decoder: reclocking, DAC formatting,
   bit decoder source and the host misc space. Trellis decoder, bit decoder
   and DAC serial control live outside and connect through the ports. */

`timescale 1ns/100ps

module multihTop (
  input  logic                               ck933,
  input  logic                               rs,
  input  demodPkg::hostReq_t                 hostReq_i,
  output demodPkg::hostRsp_t                 hostRsp_o,
  input  demodPkg::demodMode_t               demodMode_i,
  input  demodPkg::dacSel_t [2:0]            dacSel_i,
  input  logic [2:0][demodPkg::DacWidth-1:0] dacData_i,
  input  demodPkg::trellisChan_t [2:0]       trellisChan_i,
  input  demodPkg::decIn_t                   trellisDec_i,
  input  demodPkg::decIn_t                   legacyDec_i,
  output logic [2:0][demodPkg::DacWidth-1:0] dacOut_o,
  output logic                               dacRst_o,
  output demodPkg::decIn_t                   decOut_o,
  input  logic                               bsyncLock_i,
  output logic                               bsyncNLock_o,
  input  logic                               demodLock_i,
  output logic                               demodNLock_o,
  input  logic                               sdi_i,
  output logic                               sdi_o
);

  import demodPkg::*;

  logic                      softReset;
  logic                      coreReset;
  logic [2:0][DacWidth-1:0]  dacDataIn;    // Reclocked inputs
  trellisChan_t [2:0]        trellisChanIn;
  decIn_t                    trellisDecIn;
  decIn_t                    legacyDecIn;

  //**********************************************************
  // Pass-throughs
  //**********************************************************
  assign bsyncNLock_o = bsyncLock_i;
  assign demodNLock_o = demodLock_i;
  assign sdi_o        = sdi_i;
  assign dacRst_o     = coreReset;     // DAC reset follows core reset

  //**********************************************************
  // Host and reset
  //**********************************************************
  hostRegs i_hostRegs (
    .ck933       (ck933),
    .rs          (rs),
    .hostReq_i   (hostReq_i),
    .hostRsp_o   (hostRsp_o),
    .softReset_o (softReset)
  );

  resetGen i_resetGen (
    .ck933       (ck933),
    .rs          (rs),
    .softReset_i (softReset),
    .coreReset_o (coreReset)
  );

  //**********************************************************
  // Input reclock
  //**********************************************************
  inputReclock i_inputReclock (
    .ck933         (ck933),
    .rs            (rs),
    .dacData_i     (dacData_i),
    .trellisChan_i (trellisChan_i),
    .trellisDec_i  (trellisDec_i),
    .legacyDec_i   (legacyDec_i),
    .dacData_o     (dacDataIn),
    .trellisChan_o (trellisChanIn),
    .trellisDec_o  (trellisDecIn),
    .legacyDec_o   (legacyDecIn)
  );

  //**********************************************************
  // DAC channels
  //**********************************************************
  dacChannel i_dac0 (
    .ck933       (ck933),
    .coreReset_i (coreReset),
    .dacSel_i    (dacSel_i[0]),
    .demodMode_i (demodMode_i),
    .direct_i    (dacDataIn[0]),
    .trellis_i   (trellisChanIn[0]),
    .dacOut_o    (dacOut_o[0])
  );

  dacChannel i_dac1 (
    .ck933       (ck933),
    .coreReset_i (coreReset),
    .dacSel_i    (dacSel_i[1]),
    .demodMode_i (demodMode_i),
    .direct_i    (dacDataIn[1]),
    .trellis_i   (trellisChanIn[1]),
    .dacOut_o    (dacOut_o[1])
  );

  dacChannel i_dac2 (
    .ck933       (ck933),
    .coreReset_i (coreReset),
    .dacSel_i    (dacSel_i[2]),
    .demodMode_i (demodMode_i),
    .direct_i    (dacDataIn[2]),
    .trellis_i   (trellisChanIn[2]),
    .dacOut_o    (dacOut_o[2])
  );

  // Bit decoder feed
  decoderSourceSelect i_decSel (
    .ck933        (ck933),
    .coreReset_i  (coreReset),
    .demodMode_i  (demodMode_i),
    .trellisDec_i (trellisDecIn),
    .legacyDec_i  (legacyDecIn),
    .decOut_o     (decOut_o)
  );

endmodule

/* tb/multihTopTb.sv */
/* Testbench for multihTop. Concurrent checks compare the DUT with a latency model.
   DAC and decoder checks are switched off around resets, when the model has no history. */

`timescale 1ns/100ps

module multihTopTb;

  import demodPkg::*;

  logic                     ck933;
  logic                     rs;
  hostReq_t                 hostReq;
  hostRsp_t                 hostRsp;
  demodMode_t               demodMode;
  dacSel_t [2:0]            dacSel;
  logic [2:0][DacWidth-1:0] dacData;
  trellisChan_t [2:0]       trellisChan;
  decIn_t                   trellisDec;
  decIn_t                   legacyDec;
  logic [2:0][DacWidth-1:0] dacOut;
  logic                     dacRst;
  decIn_t                   decOut;
  logic                     bsyncLock;
  logic                     bsyncNLock;
  logic                     demodLock;
  logic                     demodNLock;
  logic                     sdiIn;
  logic                     sdiOut;

  // Latency model state
  dacSel_t [2:0]            selDly;
  demodMode_t               modeDly;
  logic [2:0][DacWidth-1:0] dataDly1;
  logic [2:0][DacWidth-1:0] dataDly2;
  logic [2:0][DacWidth-1:0] expDac;
  trellisChan_t [2:0]       trDly1;
  trellisChan_t [2:0]       trDly2;
  decIn_t                   trDecDly1;
  decIn_t                   legDecDly1;
  decIn_t                   legDecDly2;
  decIn_t                   expDec;
  logic [HostDataWidth-1:0] expRdData;

  logic dacCheckOn = 1'b0;
  logic decCheckOn = 1'b0;
  logic randomOn = 1'b0;
  int   errCount = 0;
  int   timeoutCount = 0;

  multihTop i_dut (
    .ck933         (ck933),
    .rs            (rs),
    .hostReq_i     (hostReq),
    .hostRsp_o     (hostRsp),
    .demodMode_i   (demodMode),
    .dacSel_i      (dacSel),
    .dacData_i     (dacData),
    .trellisChan_i (trellisChan),
    .trellisDec_i  (trellisDec),
    .legacyDec_i   (legacyDec),
    .dacOut_o      (dacOut),
    .dacRst_o      (dacRst),
    .decOut_o      (decOut),
    .bsyncLock_i   (bsyncLock),
    .bsyncNLock_o  (bsyncNLock),
    .demodLock_i   (demodLock),
    .demodNLock_o  (demodNLock),
    .sdi_i         (sdiIn),
    .sdi_o         (sdiOut)
  );

  initial begin
    ck933 = 1'b0;
    forever #10 ck933 = ~ck933;       // 20 ns period
  end

  //**********************************************************
  // Expected values
  //**********************************************************
  function automatic logic [DacWidth-1:0] toOffsetBinary(input logic [DacWidth-1:0] s);
    toOffsetBinary = s ^ {1'b1, {(DacWidth-1){1'b0}}};
  endfunction

  function automatic logic isTrellisSel(input dacSel_t s);
    isTrellisSel = (s == DacTrellisI) || (s == DacTrellisQ) ||
                   (s == DacTrellisPhErr) || (s == DacTrellisIndex);
  endfunction

  // Only the upper half of the version word is nonzero
  function automatic logic [HostDataWidth-1:0] expectedReadData(input logic [11:0] byteAddr);
    if (byteAddr == MiscVersionAddr + 12'd2) begin
      expectedReadData = VerNumber;
    end else begin
      expectedReadData = '0;
    end
  endfunction

  // Select acts 2 cycles later, data 3 cycles later
  always @(posedge ck933) begin
    selDly   <= dacSel;
    modeDly  <= demodMode;
    dataDly1 <= dacData;
    dataDly2 <= dataDly1;
    trDly1   <= trellisChan;
    trDly2   <= trDly1;
    for (int c = 0; c < 3; c++) begin
      if (isTrellisSel(selDly[c]) && (modeDly == ModeMultih)) begin
        if (trDly2[c].sync) begin
          expDac[c] <= toOffsetBinary(trDly2[c].data[TrellisWidth-1 -: DacWidth]);
        end
      end else begin
        expDac[c] <= toOffsetBinary(dataDly2[c]);
      end
    end
    trDecDly1  <= trellisDec;
    legDecDly1 <= legacyDec;
    legDecDly2 <= legDecDly1;
    if (demodMode == ModeMultih) begin
      expDec <= trDecDly1;           // 2 cycles overall
    end else begin
      expDec <= legDecDly2;          // 3 cycles overall
    end
    if (hostReq.cs && hostReq.rd) begin
      expRdData <= expectedReadData({hostReq.addr, 1'b0});
    end
  end

  //**********************************************************
  // Concurrent checks
  //**********************************************************
  for (genvar c = 0; c < 3; c++) begin : gDacCheck
    aDacOut : assert property (
      @(posedge ck933) disable iff (!dacCheckOn) dacOut[c] == expDac[c]
    ) else begin
      errCount++;
      $display("ERR dacOut_o[%0d] got %h exp %h", c, $sampled(dacOut[c]),
               $sampled(expDac[c]));
    end
  end

  aDacRstValue : assert property (
    @(posedge ck933) dacRst |-> dacOut == {3{14'h2000}}
  ) else begin
    errCount++;
    $display("ERR dacOut_o got %h exp %h", $sampled(dacOut), {3{14'h2000}});
  end

  aDecRstValue : assert property (
    @(posedge ck933) dacRst |-> !decOut.symEn && !decOut.sym2xEn
  ) else begin
    errCount++;
    $display("ERR decOut_o enables got %h exp %h",
             $sampled({decOut.symEn, decOut.sym2xEn}), 2'b00);
  end

  aResetWidth : assert property (
    @(posedge ck933) disable iff (rs) $rose(dacRst) |-> dacRst [*ResetStretch]
  ) else begin
    errCount++;
    $display("dacRst_o pulse ended before the stretch length");
  end

  aDecOut : assert property (
    @(posedge ck933) disable iff (!decCheckOn) decOut == expDec
  ) else begin
    errCount++;
    $display("ERR decOut_o got %h exp %h", $sampled(decOut), $sampled(expDec));
  end

  aReadValid : assert property (
    @(posedge ck933) disable iff (rs) (hostReq.cs && hostReq.rd) |=> hostRsp.rdValid
  ) else begin
    errCount++;
    $display("ERR hostRsp_o.rdValid got %h exp %h", $sampled(hostRsp.rdValid), 1'b1);
  end

  aReadData : assert property (
    @(posedge ck933) disable iff (rs)
    (hostReq.cs && hostReq.rd) |=> hostRsp.rdData == expRdData
  ) else begin
    errCount++;
    $display("ERR hostRsp_o.rdData got %h exp %h", $sampled(hostRsp.rdData),
             $sampled(expRdData));
  end

  aNoStrayValid : assert property (
    @(posedge ck933) disable iff (rs) !(hostReq.cs && hostReq.rd) |=> !hostRsp.rdValid
  ) else begin
    errCount++;
    $display("ERR hostRsp_o.rdValid got %h exp %h", $sampled(hostRsp.rdValid), 1'b0);
  end

  aPassThrough : assert property (
    @(posedge ck933) {bsyncNLock, demodNLock, sdiOut} == {bsyncLock, demodLock, sdiIn}
  ) else begin
    errCount++;
    $display("ERR lock/sdi outputs got %h exp %h", $sampled({bsyncNLock, demodNLock, sdiOut}),
             $sampled({bsyncLock, demodLock, sdiIn}));
  end

  //**********************************************************
  // Stimulus helpers
  //**********************************************************
  task automatic randomizeData();
    for (int c = 0; c < 3; c++) begin
      dacData[c]          = DacWidth'($urandom);
      trellisChan[c].data = TrellisWidth'($urandom);
      trellisChan[c].sync = ($urandom % 3) != 0;   // Low about a third of the time
    end
    trellisDec = 4'($urandom);
    legacyDec  = 4'($urandom);
    bsyncLock  = 1'($urandom);
    demodLock  = 1'($urandom);
    sdiIn      = 1'($urandom);
  endtask

  task automatic nextCycle();
    @(posedge ck933);
    #2;
    if (randomOn) begin
      randomizeData();
    end
  endtask

  task automatic runCycles(input int n);
    repeat (n) nextCycle();
  endtask

  task automatic hostRead(input logic [11:0] byteAddr);
    hostReq.cs     = 1'b1;
    hostReq.rd     = 1'b1;
    hostReq.wr     = 1'b0;
    hostReq.addr   = byteAddr[11:1];
    hostReq.wrData = '0;
    nextCycle();
    hostReq = '0;
  endtask

  task automatic hostWrite(input logic [11:0] byteAddr, input logic [15:0] data);
    hostReq.cs     = 1'b1;
    hostReq.rd     = 1'b0;
    hostReq.wr     = 1'b1;
    hostReq.addr   = byteAddr[11:1];
    hostReq.wrData = data;
    nextCycle();
    hostReq = '0;
  endtask

  task automatic waitForReset(input logic level, input int limit);
    int cycles;
    cycles = 0;
    while ((dacRst !== level) && (cycles < limit)) begin
      nextCycle();
      cycles++;
    end
    if (dacRst !== level) begin
      timeoutCount++;
      $display("Timeout: dacRst_o did not reach %0b within %0d cycles", level, limit);
    end
  endtask

  task automatic checkAddressMap();
    hostRead(12'hF06);
    hostRead(12'hF04);
    hostRead(12'hF00);
    runCycles(1);
    repeat (6) hostRead(12'($urandom) & 12'hFFE);   // Back to back
    runCycles(2);
  endtask

  //**********************************************************
  // Main sequence
  //**********************************************************
  initial begin
    void'($urandom(32'hbdb2_9140));
    rs          = 1'b1;
    hostReq     = '0;
    demodMode   = ModeLegacy;
    dacSel      = '{DacDirect, DacDirect, DacDirect};
    dacData     = '0;
    trellisChan = '0;
    trellisDec  = '0;
    legacyDec   = '0;
    bsyncLock   = 1'b0;
    demodLock   = 1'b0;
    sdiIn       = 1'b0;

    repeat (16) @(posedge ck933);
    #2;
    rs       = 1'b0;
    randomOn = 1'b1;
    waitForReset(1'b0, ResetStretch + 4);
    runCycles(4);                     // Let the model fill
    dacCheckOn = 1'b1;
    decCheckOn = 1'b1;

    checkAddressMap();

    // Direct path, trellis selects ignored outside multi-h
    dacSel = '{DacTrellisPhErr, DacTrellisQ, DacTrellisI};
    runCycles(20);
    demodMode = ModeMultih;
    dacSel    = '{DacDirect, DacDirect, DacDirect};
    runCycles(20);
    demodMode = ModeAuqpsk;
    dacSel    = '{DacTrellisIndex, DacTrellisQ, DacTrellisI};
    runCycles(20);

    // Trellis path with sync gaps
    demodMode = ModeMultih;
    runCycles(40);
    dacSel[0] = DacDirect;
    dacSel[2] = DacTrellisPhErr;
    runCycles(20);
    demodMode = ModeLegacy;
    runCycles(10);

    // Soft reset through the misc space
    dacCheckOn = 1'b0;
    decCheckOn = 1'b0;
    hostWrite(MiscResetAddr, 16'h0001);
    waitForReset(1'b1, 4);
    waitForReset(1'b0, ResetStretch + 4);
    runCycles(4);
    dacCheckOn = 1'b1;
    decCheckOn = 1'b1;
    checkAddressMap();
    demodMode = ModeMultih;
    runCycles(10);

    $display("Run complete: %0d check errors, %0d timeouts", errCount, timeoutCount);
    if ((errCount == 0) && (timeoutCount == 0)) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
hw/demodPkg.sv
hw/resetGen.sv
hw/hostRegs.sv
hw/inputReclock.sv
hw/dacChannel.sv
hw/decoderSourceSelect.sv
hw/multihTop.sv
tb/multihTopTb.sv
